/* dv/cq_tb_ref.svh */
/*
 * Reference model of the command-queue testbench
 * Flush-set type, LFSR step, command builders
 * and the expected-flush function
 */
`ifndef CQ_TB_REF_SVH
`define CQ_TB_REF_SVH

// All strobes of one executed command
typedef struct packed {
    cq_pkg::iotlb_flush_t t;
    cq_pkg::ddtc_flush_t  d;
    cq_pkg::pdtc_flush_t  p;
} flush_set_t;

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// IOTINVAL, func3 0 is VMA and 1 is GVMA
function automatic logic [127:0] build_tinval(input logic gvma, input logic av, input logic gv,
        input logic pscv, input logic [19:0] pscid, input logic [15:0] gscid,
        input logic [51:0] vpn);
    logic [127:0] e;
    e = '0;
    e[6:0]    = 7'd1;
    e[9:7]    = {2'b0, gvma};
    e[10]     = av;
    e[31:12]  = pscid;
    e[32]     = pscv;
    e[33]     = gv;
    e[59:44]  = gscid;
    e[125:74] = vpn;
    return e;
endfunction

// IODIR, func3 0 is INVAL_DDT and 1 is INVAL_PDT
function automatic logic [127:0] build_dir(input logic pdt, input logic dv,
        input logic [23:0] did, input logic [19:0] pid);
    logic [127:0] e;
    e = '0;
    e[6:0]   = 7'd3;
    e[9:7]   = {2'b0, pdt};
    e[31:12] = pid;
    e[33]    = dv;
    e[63:40] = did;
    return e;
endfunction

function automatic logic [127:0] build_fence(input logic wsi);
    logic [127:0] e;
    e = '0;
    e[6:0] = 7'd2;
    e[11]  = wsi;
    return e;
endfunction

// Expected strobes and legality from the command field positions
function automatic void expect_flush(input logic [127:0] e, output flush_set_t f,
        output logic ill);
    logic [2:0] fn;
    fn  = e[9:7];
    f   = '0;
    ill = 1'b0;
    case (e[6:0])
        7'd1: begin
            ill = e[11] | (|e[43:34]) | (|e[63:60]) | (|e[73:64]) | (|e[127:126])
                | (fn > 3'd1) | ((fn == 3'd1) & e[32]);
            f.t.vma   = (fn == 3'd0);
            f.t.gvma  = (fn == 3'd1);
            f.t.av    = e[10];
            f.t.gv    = e[33];
            f.t.pscv  = (fn == 3'd0) & e[32];
            f.t.vpn   = e[125:74];
            f.t.gscid = e[59:44];
            f.t.pscid = e[31:12];
        end
        7'd2: ill = (|fn) | (|e[31:14]) | (|e[65:64]);
        7'd3: begin
            ill = (|e[11:10]) | e[32] | (|e[39:34]) | (|e[127:64]) | (fn > 3'd1)
                | ((fn == 3'd0) & (|e[31:12]));
            // Directory id travels with both directory commands
            f.d.dv    = e[33];
            f.d.did   = e[63:40];
            f.d.flush = (fn == 3'd0);
            f.p.flush = 1'b1;
            f.p.pv    = (fn == 3'd1);
            f.p.pid   = (fn == 3'd1) ? e[31:12] : '0;
        end
        default: ill = 1'b1;
    endcase
    if (ill) f = '0;
endfunction

`endif

/* dv/cq_tb.sv */
/*
 * Testbench of the command-queue handler
 * Clock, reset, memory model, register-map model,
 * stimulus sequences, strobe checker and watchdog
 */
`timescale 1ns/1ns
`include "cq_config.svh"

module cq_tb;

    `include "cq_tb_ref.svh"

    localparam int NCMD     = 600;
    localparam int WATCH_NS = NCMD * 24 * 8;

    logic                  clk_i, rst_ni;
    logic [`CQ_PPN_W-1:0]  cq_base;
    logic [4:0]            cq_size;
    logic                  cq_en, cq_ie, clr_err;
    logic [`CQ_IDX_W-1:0]  cq_tail, head_r, tail_sw;
    logic                  mf_r, to_r, ill_r, fence_r;
    logic [`CQ_IDX_W-1:0]  cq_head_o;
    logic                  cq_on_o, busy_o, error_o, cq_mf_o, cmd_to_o, cmd_ill_o;
    logic                  fence_w_ip_o, cq_ip_o;
    cq_pkg::mem_req_t      mem_req;
    cq_pkg::mem_rsp_t      mem_rsp;
    cq_pkg::iotlb_flush_t  iotlb_flush;
    cq_pkg::ddtc_flush_t   ddtc_flush;
    cq_pkg::pdtc_flush_t   pdtc_flush;
    logic [127:0]          mem [0:511];
    logic [`CQ_PLEN-1:0]   fault_addr;
    logic [15:0]           mem_lfsr, stim_lfsr;
    flush_set_t            exp_q[$];

    cq_handler dut0 (
        .clk_i(clk_i), .rst_ni(rst_ni), .cq_base_ppn_i(cq_base), .cq_size_i(cq_size),
        .cq_en_i(cq_en), .cq_ie_i(cq_ie), .cq_tail_i(cq_tail), .cq_head_i(head_r),
        .cq_head_o(cq_head_o), .cq_on_o(cq_on_o), .busy_o(busy_o),
        .cq_mf_i(mf_r), .cmd_to_i(to_r), .cmd_ill_i(ill_r), .fence_w_ip_i(fence_r),
        .error_o(error_o), .cq_mf_o(cq_mf_o), .cmd_to_o(cmd_to_o), .cmd_ill_o(cmd_ill_o),
        .fence_w_ip_o(fence_w_ip_o), .cq_ip_o(cq_ip_o),
        .mem_req_o(mem_req), .mem_rsp_i(mem_rsp),
        .iotlb_flush_o(iotlb_flush), .ddtc_flush_o(ddtc_flush), .pdtc_flush_o(pdtc_flush)
    );

    task automatic report_failure(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1);
    endtask

    // Step the LFSR once per bit taken
    function automatic logic [31:0] take_bits(inout logic [15:0] s, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = {v[30:0], s[0]};
        end
        return v;
    endfunction

    // 8 index bits for small queues, size plus one bits beyond
    function automatic logic [`CQ_IDX_W-1:0] ring_mask();
        if (cq_size <= 5'd7) return 32'hFF;
        return (32'd1 << (cq_size + 1)) - 1;
    endfunction

    function automatic logic [127:0] random_cmd();
        logic [2:0] kind;
        kind = take_bits(stim_lfsr, 3) % 5;
        case (kind)
            3'd0, 3'd1: return build_tinval(kind[0], take_bits(stim_lfsr, 1),
                take_bits(stim_lfsr, 1), ~kind[0] & take_bits(stim_lfsr, 1),
                take_bits(stim_lfsr, 20), take_bits(stim_lfsr, 16),
                {take_bits(stim_lfsr, 20), take_bits(stim_lfsr, 32)});
            3'd2: return build_dir(1'b0, take_bits(stim_lfsr, 1), take_bits(stim_lfsr, 24), '0);
            3'd3: return build_dir(1'b1, take_bits(stim_lfsr, 1), take_bits(stim_lfsr, 24),
                take_bits(stim_lfsr, 20));
            default: return build_fence(1'b0);
        endcase
    endfunction

    // Write one entry at the software tail
    task automatic post_entry(input logic [127:0] e, input logic expect_it);
        flush_set_t f;
        logic       ill;
        expect_flush(e, f, ill);
        mem[tail_sw] = e;
        if (expect_it && (f.t.vma | f.t.gvma | f.d.flush | f.p.flush)) exp_q.push_back(f);
        tail_sw = (tail_sw + 1) & ring_mask();
    endtask

    task automatic commit_tail();
        @(posedge clk_i);
        cq_tail <= tail_sw;
    endtask

    task automatic drain_queue();
        commit_tail();
        @(posedge clk_i);
        while (head_r != tail_sw) @(posedge clk_i);
        assert (exp_q.size() == 0) else report_failure("commands left without strobes");
    endtask

    task automatic random_batch(input int n);
        for (int i = 0; i < n; i++) post_entry(random_cmd(), 1'b1);
        drain_queue();
    endtask

    task automatic clear_errors();
        @(posedge clk_i);
        clr_err <= 1'b1;
        @(posedge clk_i);
        clr_err <= 1'b0;
    endtask

    // Busy for one cycle, then on follows enable
    task automatic set_enable(input logic v);
        @(posedge clk_i);
        cq_en <= v;
        @(posedge clk_i);
        assert (busy_o && cq_on_o) else report_failure("busy/on wrong while enable changes");
        @(posedge clk_i);
        assert (!busy_o && cq_on_o == v) else report_failure("busy/on wrong after enable");
        if (v) begin
            assert (head_r == 0 && !mf_r && !to_r && !ill_r && !fence_r)
                else report_failure("head or error bits not cleared on enable");
        end
    endtask

    // Illegal entry stops the queue, a legal one replaces it after the clear
    task automatic check_illegal(input logic [127:0] e, input logic ie);
        logic [`CQ_IDX_W-1:0] h;
        h = head_r;
        cq_ie <= ie;
        post_entry(e, 1'b0);
        commit_tail();
        while (!ill_r) @(posedge clk_i);
        assert (head_r == h && error_o && cq_ip_o == ie)
            else report_failure("illegal command handled wrongly");
        repeat (6) begin
            @(posedge clk_i);
            assert (!mem_req.req) else report_failure("fetch while error pending");
        end
        mem[h] = build_dir(1'b1, 1'b1, 24'h00C0DE, 20'h0BEEF);
        exp_q.push_back({cq_pkg::iotlb_flush_t'('0), 1'b0, 1'b1, 24'h00C0DE,
                         1'b1, 1'b1, 20'h0BEEF});
        clear_errors();
        drain_queue();
    endtask

    // Faulting read of a legal entry holds the head, the clean retry executes it
    task automatic check_fault();
        logic [`CQ_IDX_W-1:0] h;
        logic [127:0]         e;
        flush_set_t           f;
        logic                 ill;
        h = head_r;
        e = build_dir(1'b0, 1'b1, 24'h0000A5, 20'h0);
        fault_addr = {cq_base, 12'b0} + `CQ_PLEN'(tail_sw << 4);
        post_entry(e, 1'b0);
        commit_tail();
        while (!mf_r) @(posedge clk_i);
        assert (head_r == h && error_o && !ill_r && cq_ip_o == cq_ie)
            else report_failure("memory fault handled wrongly");
        repeat (6) begin
            @(posedge clk_i);
            assert (!mem_req.req) else report_failure("fetch while fault pending");
        end
        fault_addr = '1;
        expect_flush(e, f, ill);
        exp_q.push_back(f);
        clear_errors();
        drain_queue();
    endtask

    // Clock and reset
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Register-map model stores the handler outputs each clock
    always @(posedge clk_i) begin
        if (rst_ni) begin
            head_r  <= cq_head_o;
            mf_r    <= cq_mf_o & ~clr_err;
            to_r    <= cmd_to_o & ~clr_err;
            ill_r   <= cmd_ill_o & ~clr_err;
            fence_r <= fence_w_ip_o;
        end
    end

    // Memory model, random grant and read latency
    initial begin
        logic [`CQ_PLEN-1:0] addr;
        logic [`CQ_PLEN-1:0] exp_addr;
        int                  gap;
        forever begin
            @(posedge clk_i);
            if (mem_req.req) begin
                addr     = mem_req.addr;
                exp_addr = {cq_base, 12'b0} + `CQ_PLEN'((head_r & ring_mask()) << 4);
                assert (addr == exp_addr) else report_failure($sformatf(
                    "entry address %h, expected %h", addr, exp_addr));
                gap = take_bits(mem_lfsr, 2);
                repeat (gap) @(posedge clk_i);
                mem_rsp.gnt <= 1'b1;
                @(posedge clk_i);
                mem_rsp.gnt <= 1'b0;
                gap = take_bits(mem_lfsr, 2);
                repeat (gap) @(posedge clk_i);
                mem_rsp.rvalid <= 1'b1;
                mem_rsp.err    <= (addr == fault_addr);
                mem_rsp.rdata  <= mem[(addr - {cq_base, 12'b0}) >> 4];
                @(posedge clk_i);
                mem_rsp.rvalid <= 1'b0;
            end
        end
    end

    // Strobe checker, one expected set per strobe cycle
    always @(posedge clk_i) begin
        if (iotlb_flush.vma | iotlb_flush.gvma | ddtc_flush.flush | pdtc_flush.flush) begin
            assert (exp_q.size() != 0) else report_failure("strobe with no command pending");
            assert ({iotlb_flush, ddtc_flush, pdtc_flush} == exp_q[0])
                else report_failure($sformatf("strobes %h, expected %h",
                    {iotlb_flush, ddtc_flush, pdtc_flush}, exp_q[0]));
            void'(exp_q.pop_front());
        end
    end

    initial begin
        #(WATCH_NS);
        $display("Watchdog expired before all commands were processed");
        $display("test failed");
        $fatal(1);
    end

    initial begin
        rst_ni = 1'b0;
        cq_base = 44'h123_4567_89A;
        cq_size = 5'd2;
        cq_en = 1'b0;
        cq_ie = 1'b0;
        clr_err = 1'b0;
        cq_tail = '0;
        tail_sw = '0;
        // Stale register values that enable must clear
        head_r = 32'd5;
        mf_r = 1'b1;
        to_r = 1'b1;
        ill_r = 1'b0;
        fence_r = 1'b1;
        mem_rsp = '0;
        fault_addr = '1;
        mem_lfsr = 16'd49872;
        stim_lfsr = 16'd49872;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        assert (!busy_o && !cq_on_o && !cq_ip_o) else report_failure("busy/on set after reset");
        // Timeout bit follows the register map while disabled
        assert (cmd_to_o) else report_failure("timeout bit not passed through");
        set_enable(1'b1);
        // Random stream past the 256-entry wrap
        for (int b = 0; b < 11; b++) random_batch(24);
        // Fence interrupt bit
        post_entry(build_fence(1'b0), 1'b0);
        drain_queue();
        assert (!fence_r) else report_failure("fence bit set without wsi");
        post_entry(build_fence(1'b1), 1'b0);
        drain_queue();
        assert (fence_r) else report_failure("fence bit not set with wsi");
        post_entry(build_fence(1'b0), 1'b0);
        drain_queue();
        assert (fence_r) else report_failure("fence bit changed without wsi");
        // Illegal commands, interrupt enable alternating
        check_illegal(build_tinval(1'b0, 1, 0, 0, 20'h1, 16'h2, 52'h3) | 128'h800, 1'b1);
        check_illegal(build_tinval(1'b1, 0, 1, 1, 20'h4, 16'h5, 52'h6), 1'b0);
        check_illegal(build_dir(1'b0, 1'b1, 24'h7, 20'h8), 1'b1);
        check_illegal(128'h4, 1'b0);
        check_illegal(128'h15, 1'b1);
        // Memory fault holds the head
        check_fault();
        // Wide mask with a new base page
        set_enable(1'b0);
        cq_size <= 5'd8;
        cq_base <= 44'hFED_CBA9_876;
        tail_sw = '0;
        cq_tail <= '0;
        set_enable(1'b1);
        for (int b = 0; b < 11; b++) random_batch(24);
        $display("test passed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
+incdir+dv
verilog/cq_pkg.sv
verilog/cq_queue_ctrl.sv
verilog/cq_fetch.sv
verilog/cq_cmd_exec.sv
verilog/cq_handler.sv
dv/cq_tb.sv

/* verilog/cq_cmd_exec.sv */
/*
 * Execute stage of the command-queue handler
 * Decode of the fetched entry, illegal-command checks,
 * registered invalidation strobes and the command result
 */
`timescale 1ns/1ns
`include "cq_config.svh"

module cq_cmd_exec (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  entry_valid_i,
    input  logic                  entry_fault_i,
    input  cq_pkg::cq_entry_t     entry_i,
    output cq_pkg::cmd_result_t   result_o,
    output cq_pkg::iotlb_flush_t  iotlb_flush_o,
    output cq_pkg::ddtc_flush_t   ddtc_flush_o,
    output cq_pkg::pdtc_flush_t   pdtc_flush_o
);

    cq_pkg::cq_iotinval_t cmd_tinv;
    cq_pkg::cq_iofence_t  cmd_fence;
    cq_pkg::cq_iodir_t    cmd_dir;

    logic                 illegal;
    logic                 fence_wsi;
    logic                 go;
    cq_pkg::iotlb_flush_t iotlb_n;
    cq_pkg::ddtc_flush_t  ddtc_n;
    cq_pkg::pdtc_flush_t  pdtc_n;

    // Same 128 bits seen through each command layout
    assign cmd_tinv  = cq_pkg::cq_iotinval_t'(entry_i);
    assign cmd_fence = cq_pkg::cq_iofence_t'(entry_i);
    assign cmd_dir   = cq_pkg::cq_iodir_t'(entry_i);

    always_comb begin
        illegal   = 1'b0;
        fence_wsi = 1'b0;
        iotlb_n   = '0;
        ddtc_n    = '0;
        pdtc_n    = '0;

        case (entry_i.opcode)
            cq_pkg::IOTINVAL: begin
                iotlb_n.av    = cmd_tinv.av;
                iotlb_n.gv    = cmd_tinv.gv;
                iotlb_n.vpn   = cmd_tinv.addr;
                iotlb_n.gscid = cmd_tinv.gscid;
                iotlb_n.pscid = cmd_tinv.pscid;
                illegal = (|cmd_tinv.rsvd0) | (|cmd_tinv.rsvd1) | (|cmd_tinv.rsvd2)
                        | (|cmd_tinv.rsvd3) | cmd_tinv.rsvd_b;
                case (cmd_tinv.func3)
                    cq_pkg::VMA: begin
                        iotlb_n.vma  = 1'b1;
                        iotlb_n.pscv = cmd_tinv.pscv;
                    end
                    // PSCV has no meaning for second-stage entries
                    cq_pkg::GVMA: begin
                        iotlb_n.gvma = 1'b1;
                        if (cmd_tinv.pscv) illegal = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end

            cq_pkg::IOFENCE: begin
                // Only IOFENCE.C (func3 0) is defined
                illegal   = (|cmd_fence.rsvd0) | (|cmd_fence.rsvd1) | (|cmd_fence.func3);
                fence_wsi = cmd_fence.wsi;
            end

            cq_pkg::IODIR: begin
                ddtc_n.dv  = cmd_dir.dv;
                ddtc_n.did = cmd_dir.did;
                illegal = (|cmd_dir.rsvd0) | (|cmd_dir.rsvd1) | (|cmd_dir.rsvd2)
                        | (|cmd_dir.rsvd3);
                case (cmd_dir.func3)
                    // DDT flush also drops every cached process context
                    cq_pkg::INVAL_DDT: begin
                        ddtc_n.flush = 1'b1;
                        pdtc_n.flush = 1'b1;
                        if (|cmd_dir.pid) illegal = 1'b1;
                    end
                    cq_pkg::INVAL_PDT: begin
                        pdtc_n.flush = 1'b1;
                        pdtc_n.pv    = 1'b1;
                        pdtc_n.pid   = cmd_dir.pid;
                    end
                    default: illegal = 1'b1;
                endcase
            end

            // ATS and unknown opcodes
            default: illegal = 1'b1;
        endcase
    end

    // Strobes only for a fault-free, legal command
    assign go = entry_valid_i & ~entry_fault_i & ~illegal;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            result_o      <= '0;
            iotlb_flush_o <= '0;
            ddtc_flush_o  <= '0;
            pdtc_flush_o  <= '0;
        end else begin
            result_o.valid     <= entry_valid_i & ~entry_fault_i;
            result_o.illegal   <= illegal;
            result_o.fence_wsi <= fence_wsi & go;
            iotlb_flush_o      <= go ? iotlb_n : '0;
            ddtc_flush_o       <= go ? ddtc_n : '0;
            pdtc_flush_o       <= go ? pdtc_n : '0;
        end
    end

endmodule

/* verilog/cq_config.svh */
/*
 * Widths and sizes of the command-queue handler
 * Address, index and identifier widths, entry size,
 * and the largest size code that keeps the 8-bit head mask
 */
`ifndef CQ_CONFIG_SVH
`define CQ_CONFIG_SVH

// Memory addressing
`define CQ_PPN_W 44
`define CQ_PLEN 56

// Head and tail indexes
`define CQ_IDX_W 32

// Identifier widths of the invalidation targets
`define CQ_DID_W 24
`define CQ_PID_W 20
`define CQ_PSCID_W 20
`define CQ_GSCID_W 16
`define CQ_VPN_W 52

// One command is 16 bytes
`define CQ_ENTRY_W 128

// Size codes up to this value share one 4 KiB page
`define CQ_SMALL_LOG 7

`endif

/* verilog/cq_fetch.sv */
/*
 * Fetch stage of the command-queue handler
 * Entry address generation, request with grant wait,
 * capture of the returned entry and its fault flag
 */
`timescale 1ns/1ns
`include "cq_config.svh"

module cq_fetch (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [`CQ_PPN_W-1:0]  cq_base_ppn_i,
    input  logic                  fetch_start_i,
    input  logic [`CQ_IDX_W-1:0]  fetch_idx_i,
    input  cq_pkg::mem_rsp_t      mem_rsp_i,
    output cq_pkg::mem_req_t      mem_req_o,
    output logic                  entry_valid_o,
    output cq_pkg::cq_entry_t     entry_o,
    output logic                  entry_fault_o
);

    typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT} fetch_state_e;

    fetch_state_e        state_q;
    logic [`CQ_PLEN-1:0] addr_q;
    logic                valid_q;
    cq_pkg::cq_entry_t   entry_q;
    logic                fault_q;

    // Request stays up with a stable address until granted
    assign mem_req_o.req  = (state_q == F_REQ);
    assign mem_req_o.addr = addr_q;

    assign entry_valid_o = valid_q;
    assign entry_o       = entry_q;
    assign entry_fault_o = fault_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= F_IDLE;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                F_IDLE: if (fetch_start_i) state_q <= F_REQ;
                F_REQ:  if (mem_rsp_i.gnt) state_q <= F_WAIT;
                F_WAIT: begin
                    if (mem_rsp_i.rvalid) begin
                        valid_q <= 1'b1;
                        state_q <= F_IDLE;
                    end
                end
                default: state_q <= F_IDLE;
            endcase
        end
    end

    // Entry address is base page plus 16 bytes per index
    always_ff @(posedge clk_i) begin
        if (state_q == F_IDLE && fetch_start_i) begin
            addr_q <= {cq_base_ppn_i, 12'b0} + `CQ_PLEN'({fetch_idx_i, 4'b0});
        end
    end

    // Returned entry and fault, held for the execute stage
    always_ff @(posedge clk_i) begin
        if (state_q == F_WAIT && mem_rsp_i.rvalid) begin
            entry_q <= cq_pkg::cq_entry_t'(mem_rsp_i.rdata);
            fault_q <= mem_rsp_i.err;
        end
    end

endmodule

/* verilog/cq_handler.sv */
/*
 * Command-queue handler top level
 * Queue controller, fetch stage and execute stage
 */
`timescale 1ns/1ns
`include "cq_config.svh"

module cq_handler (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Register map
    input  logic [`CQ_PPN_W-1:0]  cq_base_ppn_i,
    input  logic [4:0]            cq_size_i,
    input  logic                  cq_en_i,
    input  logic                  cq_ie_i,
    input  logic [`CQ_IDX_W-1:0]  cq_tail_i,
    input  logic [`CQ_IDX_W-1:0]  cq_head_i,
    output logic [`CQ_IDX_W-1:0]  cq_head_o,
    output logic                  cq_on_o,
    output logic                  busy_o,
    input  logic                  cq_mf_i,
    input  logic                  cmd_to_i,
    input  logic                  cmd_ill_i,
    input  logic                  fence_w_ip_i,
    output logic                  error_o,
    output logic                  cq_mf_o,
    output logic                  cmd_to_o,
    output logic                  cmd_ill_o,
    output logic                  fence_w_ip_o,
    output logic                  cq_ip_o,
    // Memory read port
    output cq_pkg::mem_req_t      mem_req_o,
    input  cq_pkg::mem_rsp_t      mem_rsp_i,
    // Cache invalidations
    output cq_pkg::iotlb_flush_t  iotlb_flush_o,
    output cq_pkg::ddtc_flush_t   ddtc_flush_o,
    output cq_pkg::pdtc_flush_t   pdtc_flush_o
);

    logic                 fetch_start;
    logic [`CQ_IDX_W-1:0] fetch_idx;
    logic                 entry_valid;
    logic                 entry_fault;
    cq_pkg::cq_entry_t    entry;
    cq_pkg::cmd_result_t  result;

    cq_queue_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cq_size_i     (cq_size_i),
        .cq_en_i       (cq_en_i),
        .cq_ie_i       (cq_ie_i),
        .cq_tail_i     (cq_tail_i),
        .cq_head_i     (cq_head_i),
        .cq_mf_i       (cq_mf_i),
        .cmd_to_i      (cmd_to_i),
        .cmd_ill_i     (cmd_ill_i),
        .fence_w_ip_i  (fence_w_ip_i),
        .entry_valid_i (entry_valid),
        .entry_fault_i (entry_fault),
        .result_i      (result),
        .fetch_start_o (fetch_start),
        .fetch_idx_o   (fetch_idx),
        .cq_head_o     (cq_head_o),
        .cq_on_o       (cq_on_o),
        .busy_o        (busy_o),
        .error_o       (error_o),
        .cq_mf_o       (cq_mf_o),
        .cmd_to_o      (cmd_to_o),
        .cmd_ill_o     (cmd_ill_o),
        .fence_w_ip_o  (fence_w_ip_o),
        .cq_ip_o       (cq_ip_o)
    );

    cq_fetch u_fetch (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cq_base_ppn_i (cq_base_ppn_i),
        .fetch_start_i (fetch_start),
        .fetch_idx_i   (fetch_idx),
        .mem_rsp_i     (mem_rsp_i),
        .mem_req_o     (mem_req_o),
        .entry_valid_o (entry_valid),
        .entry_o       (entry),
        .entry_fault_o (entry_fault)
    );

    cq_cmd_exec u_exec (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .entry_valid_i (entry_valid),
        .entry_fault_i (entry_fault),
        .entry_i       (entry),
        .result_o      (result),
        .iotlb_flush_o (iotlb_flush_o),
        .ddtc_flush_o  (ddtc_flush_o),
        .pdtc_flush_o  (pdtc_flush_o)
    );

endmodule

/* verilog/cq_pkg.sv */
/*
 * Shared types of the command-queue handler
 * Opcode and func3 encodings, command entry layouts,
 * memory port structs, invalidation strobes and the stage result
 */
`include "cq_config.svh"

package cq_pkg;

    // Command opcodes and func3 encodings
    typedef enum logic [6:0] {IOTINVAL = 7'd1, IOFENCE = 7'd2, IODIR = 7'd3, ATS = 7'd4} cq_opcode_e;
    typedef enum logic [2:0] {VMA = 3'd0, GVMA = 3'd1} iotinval_func_e;
    typedef enum logic [2:0] {INVAL_DDT = 3'd0, INVAL_PDT = 3'd1} iodir_func_e;

    // Common view, opcode and func3 sit in the low bits of every command
    typedef struct packed {
        logic [`CQ_ENTRY_W-11:0] rest;
        logic [2:0]              func3;
        logic [6:0]              opcode;
    } cq_entry_t;

    // IOTINVAL.VMA / IOTINVAL.GVMA
    typedef struct packed {
        logic [1:0]             rsvd3;
        logic [`CQ_VPN_W-1:0]   addr;
        logic [9:0]             rsvd2;
        logic [3:0]             rsvd1;
        logic [`CQ_GSCID_W-1:0] gscid;
        logic [9:0]             rsvd0;
        logic                   gv;
        logic                   pscv;
        logic [`CQ_PSCID_W-1:0] pscid;
        logic                   rsvd_b;
        logic                   av;
        logic [2:0]             func3;
        logic [6:0]             opcode;
    } cq_iotinval_t;

    // IOFENCE.C, the address and data only matter when AV is set
    typedef struct packed {
        logic [61:0] addr;
        logic [1:0]  rsvd1;
        logic [31:0] data;
        logic [17:0] rsvd0;
        logic        pw;
        logic        pr;
        logic        wsi;
        logic        av;
        logic [2:0]  func3;
        logic [6:0]  opcode;
    } cq_iofence_t;

    // IODIR.INVAL_DDT / IODIR.INVAL_PDT
    typedef struct packed {
        logic [63:0]          rsvd3;
        logic [`CQ_DID_W-1:0] did;
        logic [5:0]           rsvd2;
        logic                 dv;
        logic                 rsvd1;
        logic [`CQ_PID_W-1:0] pid;
        logic [1:0]           rsvd0;
        logic [2:0]           func3;
        logic [6:0]           opcode;
    } cq_iodir_t;

    // Memory read port
    typedef struct packed {
        logic                req;
        logic [`CQ_PLEN-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                   gnt;
        logic                   rvalid;
        logic                   err;
        logic [`CQ_ENTRY_W-1:0] rdata;
    } mem_rsp_t;

    // Invalidation strobes towards the caches
    typedef struct packed {
        logic                   vma;
        logic                   gvma;
        logic                   av;
        logic                   gv;
        logic                   pscv;
        logic [`CQ_VPN_W-1:0]   vpn;
        logic [`CQ_GSCID_W-1:0] gscid;
        logic [`CQ_PSCID_W-1:0] pscid;
    } iotlb_flush_t;

    typedef struct packed {
        logic                 flush;
        logic                 dv;
        logic [`CQ_DID_W-1:0] did;
    } ddtc_flush_t;

    typedef struct packed {
        logic                 flush;
        logic                 pv;
        logic [`CQ_PID_W-1:0] pid;
    } pdtc_flush_t;

    // Outcome of one executed command
    typedef struct packed {
        logic valid;
        logic illegal;
        logic fence_wsi;
    } cmd_result_t;

endpackage

/* verilog/cq_queue_ctrl.sv */
/*
 * Queue controller of the command-queue handler
 * Enable/on/busy handshake, head masking against the tail,
 * fetch sequencing, error bits and the error hold state
 */
`timescale 1ns/1ns
`include "cq_config.svh"

module cq_queue_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [4:0]            cq_size_i,
    input  logic                  cq_en_i,
    input  logic                  cq_ie_i,
    input  logic [`CQ_IDX_W-1:0]  cq_tail_i,
    input  logic [`CQ_IDX_W-1:0]  cq_head_i,
    input  logic                  cq_mf_i,
    input  logic                  cmd_to_i,
    input  logic                  cmd_ill_i,
    input  logic                  fence_w_ip_i,
    input  logic                  entry_valid_i,
    input  logic                  entry_fault_i,
    input  cq_pkg::cmd_result_t   result_i,
    output logic                  fetch_start_o,
    output logic [`CQ_IDX_W-1:0]  fetch_idx_o,
    output logic [`CQ_IDX_W-1:0]  cq_head_o,
    output logic                  cq_on_o,
    output logic                  busy_o,
    output logic                  error_o,
    output logic                  cq_mf_o,
    output logic                  cmd_to_o,
    output logic                  cmd_ill_o,
    output logic                  fence_w_ip_o,
    output logic                  cq_ip_o
);

    // FETCH covers the whole time one command is in flight
    typedef enum logic [1:0] {IDLE, FETCH, ERROR} state_e;

    state_e               state_q, state_n;
    logic                 cq_en_q, cq_en_n;
    logic [`CQ_IDX_W-1:0] head_mask;
    logic [`CQ_IDX_W-1:0] masked_head;
    logic                 error_in;

    // Small queues live in one page, larger ones widen the mask with the size
    assign head_mask = (cq_size_i <= `CQ_SMALL_LOG) ? `CQ_IDX_W'(8'hFF)
                     : ~({`CQ_IDX_W{1'b1}} << (6'(cq_size_i) + 6'd1));
    assign masked_head = cq_head_i & head_mask;
    assign fetch_idx_o = masked_head;

    // Busy while the enable copy lags behind software
    assign busy_o  = (cq_en_i != cq_en_q);
    assign cq_on_o = cq_en_i | cq_en_q;

    // Software must clear every error bit before fetching resumes
    assign error_in = cq_mf_i | cmd_to_i | cmd_ill_i;
    assign error_o  = cq_mf_o | cmd_to_o | cmd_ill_o;

    always_comb begin
        state_n       = state_q;
        cq_en_n       = cq_en_q;
        fetch_start_o = 1'b0;
        cq_ip_o       = 1'b0;
        // Register-map bits hold unless changed below
        cq_head_o     = cq_head_i;
        cq_mf_o       = cq_mf_i;
        cmd_to_o      = cmd_to_i;
        cmd_ill_o     = cmd_ill_i;
        fence_w_ip_o  = fence_w_ip_i;

        case (state_q)
            IDLE: begin
                if (cq_en_i) begin
                    if (!cq_en_q) begin
                        // Fresh enable starts from a clean queue
                        cq_head_o    = '0;
                        cq_mf_o      = 1'b0;
                        cmd_to_o     = 1'b0;
                        cmd_ill_o    = 1'b0;
                        fence_w_ip_o = 1'b0;
                        cq_en_n      = 1'b1;
                    end else if (cq_tail_i != masked_head) begin
                        fetch_start_o = 1'b1;
                        state_n       = FETCH;
                    end
                end else if (cq_en_q) begin
                    cq_en_n = 1'b0;
                end
            end

            FETCH: begin
                if (entry_valid_i && entry_fault_i) begin
                    // Memory fault keeps the head on the failing entry
                    cq_mf_o = 1'b1;
                    state_n = ERROR;
                end else if (result_i.valid) begin
                    if (result_i.illegal) begin
                        cmd_ill_o = 1'b1;
                        state_n   = ERROR;
                    end else begin
                        cq_head_o = (masked_head + 1'b1) & head_mask;
                        // Completion of IOFENCE.C with WSI
                        if (result_i.fence_wsi) begin
                            fence_w_ip_o = 1'b1;
                        end
                        state_n = IDLE;
                    end
                end
            end

            ERROR: begin
                cq_ip_o = cq_ie_i;
                if (!error_in) begin
                    state_n = IDLE;
                end
            end

            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cq_en_q <= 1'b0;
        end else begin
            state_q <= state_n;
            cq_en_q <= cq_en_n;
        end
    end

endmodule
